//--- Makefile
TOP = execUnitTb
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps --top-module $(TOP) -f execUnit.f

sim:
	verilator --binary --assert -Wno-fatal --timescale 1ns/1ps --top-module $(TOP) \
		-Mdir obj_dir -f execUnit.f
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q -F '** PASS **' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- bench/execUnitTb.sv
module execUnitTb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int clkPeriod = 40;
  localparam int resetCycles = 8;
  localparam int numSingle = 24;
  localparam int numDiv = 4;
  localparam int numCorner = 5;
  localparam int randDivPer = 20;
  localparam int numRandom = 400;
  localparam int divLatency = execPkg::divSteps + 2; // load, steps, finish
  localparam int reqTotal = numSingle * numCorner * numCorner + 3 * numCorner * 2
    + numDiv * (numCorner * numCorner + randDivPer) + numRandom;
  localparam longint timeLimit = longint'(reqTotal) * 40 * clkPeriod;

  logic clk;
  logic rstN;
  execPkg::execReqT req;
  logic reqValid;
  logic busy;
  execPkg::execRespT resp;
  logic respValid;

  integer seed;
  int cycleCount = 0;
  int sentCount = 0;
  int respCount = 0;
  int checkCount = 0;
  int errorCount = 0;
  execPkg::execReqT sentQ[$];
  int acceptQ[$]; // cycle count right after the accepting edge

  execPkg::aluOpE singleOps[numSingle] = '{
    execPkg::opAdd, execPkg::opSub, execPkg::opAnd, execPkg::opOr,
    execPkg::opXor, execPkg::opSll, execPkg::opSrl, execPkg::opSra,
    execPkg::opBeq, execPkg::opBne, execPkg::opBlt, execPkg::opBge,
    execPkg::opBltu, execPkg::opBgeu, execPkg::opMul, execPkg::opMulh,
    execPkg::opMulhsu, execPkg::opMulhu, execPkg::opMin, execPkg::opMax,
    execPkg::opMinu, execPkg::opMaxu, execPkg::opSlt, execPkg::opSltu
  };
  execPkg::aluOpE divOps[numDiv] = '{
    execPkg::opDiv, execPkg::opDivu, execPkg::opRem, execPkg::opRemu
  };
  logic [31:0] corners[numCorner] = '{
    32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff
  };
  logic [31:0] shiftAmts[2] = '{32'hffff_ffe0, 32'hffff_ffff}; // shifts of 0 and 31 with upper bits set

  execUnit dut0 (
    .clk       (clk),
    .rstN      (rstN),
    .req       (req),
    .reqValid  (reqValid),
    .busy      (busy),
    .resp      (resp),
    .respValid (respValid)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  always @(posedge clk) cycleCount <= cycleCount + 1;

  function automatic bit isDivOp(input execPkg::aluOpE code);
    return code inside {execPkg::opDiv, execPkg::opDivu, execPkg::opRem, execPkg::opRemu};
  endfunction

  function automatic execPkg::execRespT refExec(input execPkg::execReqT r);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [63:0] prod;
    logic [4:0] sh;
    longint sa;
    longint sb;
    longint ub;
    longint unsigned ua;
    longint unsigned ubu;
    bit overflow;
    execPkg::execRespT out;
    a = r.operand1;
    b = r.operand2;
    sh = b[4:0];
    sa = $signed(a);
    sb = $signed(b);
    ub = b;
    ua = a;
    ubu = b;
    overflow = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    prod = '0;
    case (r.op.code)
      execPkg::opAdd: res = a + b;
      execPkg::opSub: res = a - b;
      execPkg::opAnd: res = a & b;
      execPkg::opOr:  res = a | b;
      execPkg::opXor: res = a ^ b;
      execPkg::opSll: res = a << sh;
      execPkg::opSrl: res = a >> sh;
      execPkg::opSra: res = $signed(a) >>> sh;
      execPkg::opBeq:  res = (a == b) ? 32'd0 : 32'd1; // 0 means taken
      execPkg::opBne:  res = (a != b) ? 32'd0 : 32'd1;
      execPkg::opBlt:  res = (sa < sb) ? 32'd0 : 32'd1;
      execPkg::opBge:  res = (sa >= sb) ? 32'd0 : 32'd1;
      execPkg::opBltu: res = (ua < ubu) ? 32'd0 : 32'd1;
      execPkg::opBgeu: res = (ua >= ubu) ? 32'd0 : 32'd1;
      execPkg::opMul: begin
        prod = sa * sb;
        res = prod[31:0];
      end
      execPkg::opMulh: begin
        prod = sa * sb;
        res = prod[63:32];
      end
      execPkg::opMulhsu: begin
        prod = sa * ub; // fits in 64 signed bits
        res = prod[63:32];
      end
      execPkg::opMulhu: begin
        prod = ua * ubu;
        res = prod[63:32];
      end
      execPkg::opDiv: begin
        if (b == 0) res = 32'hffff_ffff;
        else if (overflow) res = a;
        else res = int'(a) / int'(b);
      end
      execPkg::opRem: begin
        if (b == 0) res = a;
        else if (overflow) res = 32'd0;
        else res = int'(a) % int'(b);
      end
      execPkg::opDivu: res = (b == 0) ? 32'hffff_ffff : a / b;
      execPkg::opRemu: res = (b == 0) ? a : a % b;
      execPkg::opMin:  res = (sa < sb) ? a : b;
      execPkg::opMax:  res = (sa < sb) ? b : a;
      execPkg::opMinu: res = (ua < ubu) ? a : b;
      execPkg::opMaxu: res = (ua < ubu) ? b : a;
      execPkg::opSlt:  res = (sa < sb) ? 32'd1 : 32'd0;
      execPkg::opSltu: res = (ua < ubu) ? 32'd1 : 32'd0;
      default: res = b;
    endcase
    out.result = res;
    out.zero = (res == 32'd0);
    return out;
  endfunction

  task automatic checkIdle();
    checkCount += 2;
    assert (busy === 1'b0) else begin
      errorCount++;
      $display("[ERROR] busy exp 0 got %h", busy);
    end
    assert (respValid === 1'b0) else begin
      errorCount++;
      $display("[ERROR] respValid exp 0 got %h", respValid);
    end
  endtask

  // called on a falling edge, returns on a falling edge
  task automatic issue(input execPkg::aluOpE code, input logic [31:0] a,
                       input logic [31:0] b);
    execPkg::execReqT r;
    r.op.code = code;
    r.operand1 = a;
    r.operand2 = b;
    req = r;
    reqValid = 1'b1;
    while (busy) @(negedge clk); // held through a divide
    sentQ.push_back(r);
    acceptQ.push_back(cycleCount + 1);
    sentCount++;
    @(negedge clk);
    reqValid = 1'b0;
    if (!isDivOp(code)) @(negedge clk); // one idle cycle between responses
  endtask

  task automatic runDirected();
    for (int i = 0; i < numSingle; i++) begin
      for (int j = 0; j < numCorner; j++) begin
        for (int k = 0; k < numCorner; k++) begin
          issue(singleOps[i], corners[j], corners[k]);
        end
      end
    end
    for (int j = 0; j < numCorner; j++) begin
      for (int k = 0; k < 2; k++) begin
        issue(execPkg::opSll, corners[j], shiftAmts[k]);
        issue(execPkg::opSrl, corners[j], shiftAmts[k]);
        issue(execPkg::opSra, corners[j], shiftAmts[k]);
      end
    end
  endtask

  task automatic runDivides();
    logic [31:0] a;
    logic [31:0] b;
    int sh;
    for (int i = 0; i < numDiv; i++) begin
      // corner pairs hold the zero divisor and -2^31 / -1
      for (int j = 0; j < numCorner; j++) begin
        for (int k = 0; k < numCorner; k++) begin
          issue(divOps[i], corners[j], corners[k]);
        end
      end
      for (int n = 0; n < randDivPer; n++) begin
        a = $random(seed);
        sh = $unsigned($random(seed)) % 32;
        b = $random(seed) >>> sh; // small divisors now and then
        issue(divOps[i], a, b);
      end
    end
  endtask

  task automatic runRandom();
    int idx;
    int sh;
    logic [31:0] a;
    logic [31:0] b;
    for (int n = 0; n < numRandom; n++) begin
      idx = $unsigned($random(seed)) % (numSingle + numDiv);
      a = $random(seed);
      sh = $unsigned($random(seed)) % 32;
      b = $random(seed) >>> sh;
      if (idx < numSingle) begin
        issue(singleOps[idx], a, b);
      end else begin
        issue(divOps[idx - numSingle], a, b);
      end
    end
  endtask

  task automatic checkResponse();
    execPkg::execReqT sent;
    execPkg::execRespT expected;
    int latency;
    int expLatency;
    respCount++;
    checkCount++;
    assert (sentQ.size() != 0) else begin
      errorCount++;
      $display("a response arrived with no request outstanding");
    end
    if (sentQ.size() != 0) begin
      sent = sentQ.pop_front();
      latency = cycleCount - acceptQ.pop_front();
      expected = refExec(sent);
      expLatency = isDivOp(sent.op.code) ? divLatency : 1;
      checkCount += 3;
      assert (resp.result === expected.result) else begin
        errorCount++;
        $display("[ERROR] resp.result exp %h got %h (op %s, a %h, b %h)", expected.result,
                 resp.result, sent.op.code.name(), sent.operand1, sent.operand2);
      end
      assert (resp.zero === expected.zero) else begin
        errorCount++;
        $display("[ERROR] resp.zero exp %h got %h (op %s, a %h, b %h)", expected.zero,
                 resp.zero, sent.op.code.name(), sent.operand1, sent.operand2);
      end
      assert (latency == expLatency) else begin
        errorCount++;
        $display("response for %s came %0d cycles after acceptance instead of %0d",
                 sent.op.code.name(), latency, expLatency);
      end
    end
  endtask

  always @(negedge clk) begin
    if (rstN && respValid) checkResponse();
  end

  initial begin
    #(timeLimit);
    $display("timeout with %0d of %0d requests answered", respCount, reqTotal);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    seed = 32'h9b49_4e1b;
    rstN = 1'b0;
    reqValid = 1'b0;
    req = '0;
    repeat (resetCycles) begin
      @(negedge clk);
      checkIdle();
    end
    rstN = 1'b1;
    repeat (3) begin
      @(negedge clk);
      checkIdle();
    end
    runDirected();
    runDivides();
    runRandom();
    while (sentQ.size() != 0) @(negedge clk);
    repeat (40) @(negedge clk); // catch any stray response
    checkCount++;
    assert (respCount == sentCount) else begin
      errorCount++;
      $display("%0d responses arrived for %0d requests", respCount, sentCount);
    end
    $display("requests %0d, responses %0d, checks %0d, errors %0d",
             sentCount, respCount, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- bench/execUnit_assertions.sv
module execUnitAssertions (
  input logic             clk,
  input logic             rstN,
  input logic             busy,
  input execPkg::execReqT reqReg,
  input logic             respValid
);
  timeunit 1ns;
  timeprecision 1ps;

  respPulse: assert property (@(posedge clk) disable iff (!rstN)
    respValid |=> !respValid)
    else $error("respValid high on two cycles in a row");

  busyRelease: assert property (@(posedge clk) disable iff (!rstN)
    $fell(busy) |-> respValid)
    else $error("busy fell without respValid");

  // divider owns the request register while busy
  noAcceptBusy: assert property (@(posedge clk) disable iff (!rstN)
    busy |=> $stable(reqReg))
    else $error("request register changed while busy");

endmodule

bind execUnit execUnitAssertions asserts0 (
  .clk       (clk),
  .rstN      (rstN),
  .busy      (busy),
  .reqReg    (reqReg),
  .respValid (respValid)
);

//--- execUnit.f
src/execPkg.sv
src/aluCore.sv
src/divCounter.sv
src/divCtrl.sv
src/divDatapath.sv
src/execUnit.sv
bench/execUnit_assertions.sv
bench/execUnitTb.sv

//--- src/aluCore.sv
module aluCore (
  input  execPkg::aluOpU                op,
  input  logic [execPkg::dataWidth-1:0] operand1,
  input  logic [execPkg::dataWidth-1:0] operand2,
  output logic [execPkg::dataWidth-1:0] result
);

  localparam int dw = execPkg::dataWidth;

  logic [execPkg::shamtWidth-1:0] shamt;
  logic [2*dw-1:0] ext1Signed;
  logic [2*dw-1:0] ext2Signed;
  logic [2*dw-1:0] ext1Zero;
  logic [2*dw-1:0] ext2Zero;
  logic [2*dw-1:0] prodSs;
  logic [2*dw-1:0] prodSu;
  logic [2*dw-1:0] prodUu;
  logic eq;
  logic signedLt;
  logic unsignedLt;

  // one in bit 0, zeros above
  function automatic logic [dw-1:0] flagWord(input logic cond);
    logic [dw-1:0] w;
    w = '0;
    w[0] = cond;
    return w;
  endfunction

  assign shamt = operand2[execPkg::shamtWidth-1:0];

  assign ext1Signed = {{dw{operand1[dw-1]}}, operand1};
  assign ext2Signed = {{dw{operand2[dw-1]}}, operand2};
  assign ext1Zero = {{dw{1'b0}}, operand1};
  assign ext2Zero = {{dw{1'b0}}, operand2};

  // low 64 bits of extended products are exact
  assign prodSs = ext1Signed * ext2Signed;
  assign prodSu = ext1Signed * ext2Zero;
  assign prodUu = ext1Zero * ext2Zero;

  assign eq = operand1 == operand2;
  assign signedLt = $signed(operand1) < $signed(operand2);
  assign unsignedLt = operand1 < operand2;

  always_comb begin
    case (op.code)
      execPkg::opAdd: result = operand1 + operand2;
      execPkg::opSub: result = operand1 - operand2;
      execPkg::opAnd: result = operand1 & operand2;
      execPkg::opOr:  result = operand1 | operand2;
      execPkg::opXor: result = operand1 ^ operand2;
      execPkg::opSll: result = operand1 << shamt;
      execPkg::opSrl: result = operand1 >> shamt;
      execPkg::opSra: result = $unsigned($signed(operand1) >>> shamt);

      // branches give 0 when taken
      execPkg::opBeq:  result = flagWord(!eq);
      execPkg::opBne:  result = flagWord(eq);
      execPkg::opBlt:  result = flagWord(!signedLt);
      execPkg::opBge:  result = flagWord(signedLt);
      execPkg::opBltu: result = flagWord(!unsignedLt);
      execPkg::opBgeu: result = flagWord(unsignedLt);

      execPkg::opMul:    result = prodSs[dw-1:0];
      execPkg::opMulh:   result = prodSs[2*dw-1:dw];
      execPkg::opMulhsu: result = prodSu[2*dw-1:dw];
      execPkg::opMulhu:  result = prodUu[2*dw-1:dw];

      execPkg::opMin:  result = signedLt ? operand1 : operand2;
      execPkg::opMax:  result = signedLt ? operand2 : operand1;
      execPkg::opMinu: result = unsignedLt ? operand1 : operand2;
      execPkg::opMaxu: result = unsignedLt ? operand2 : operand1;
      execPkg::opSlt:  result = flagWord(signedLt);
      execPkg::opSltu: result = flagWord(unsignedLt);

      default: result = operand2; // divides land here too
    endcase
  end

endmodule

//--- src/divCounter.sv
module divCounter (
  input  logic clk,
  input  logic rstN,
  input  logic clear,
  input  logic enable,
  output logic last
);

  logic [execPkg::countWidth-1:0] count;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      count <= '0;
    end else if (clear) begin
      count <= '0;
    end else if (enable) begin
      count <= count + 1'b1; // wraps back to 0 after the last step
    end
  end

  assign last = enable && (count == execPkg::lastCount);

endmodule

//--- src/divCtrl.sv
module divCtrl (
  input  logic clk,
  input  logic rstN,
  input  logic start,
  input  logic last,
  output logic load,
  output logic step,
  output logic finish,
  output logic clear,
  output logic enable,
  output logic busy
);

  logic [execPkg::stateWidth-1:0] state;
  logic [execPkg::stateWidth-1:0] nextState;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= execPkg::stIdle;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    load = 1'b0;
    step = 1'b0;
    finish = 1'b0;
    clear = 1'b0;
    enable = 1'b0;
    case (state)
      execPkg::stIdle: begin
        if (start) nextState = execPkg::stLoad;
      end
      execPkg::stLoad: begin
        load = 1'b1;
        clear = 1'b1; // counter restarts with the operands
        nextState = execPkg::stIterate;
      end
      execPkg::stIterate: begin
        step = 1'b1;
        enable = 1'b1;
        if (last) nextState = execPkg::stFinish;
      end
      execPkg::stFinish: begin
        finish = 1'b1; // result handed to the top this cycle
        nextState = execPkg::stIdle;
      end
      default: nextState = execPkg::stIdle;
    endcase
  end

  assign busy = state != execPkg::stIdle;

endmodule

//--- src/divDatapath.sv
module divDatapath (
  input  logic                          clk,
  input  logic                          rstN,
  input  logic                          load,
  input  logic                          step,
  input  logic                          finish,
  input  execPkg::aluOpU                op,
  input  logic [execPkg::dataWidth-1:0] dividend,
  input  logic [execPkg::dataWidth-1:0] divisor,
  output logic [execPkg::dataWidth-1:0] result
);

  localparam int dw = execPkg::dataWidth;

  logic [dw-1:0] quot;       // dividend shifts out, quotient bits shift in
  logic [dw-1:0] rem;
  logic [dw-1:0] divMag;
  logic [dw:0] partial;
  logic [dw:0] trial;
  logic fits;
  logic dividendNeg;
  logic divisorNeg;
  logic isRemReg;
  logic negQuot;
  logic negRem;
  logic divByZero;
  logic [dw-1:0] quotFixed;
  logic [dw-1:0] remFixed;

  assign dividendNeg = !op.fields.isUnsigned && dividend[dw-1];
  assign divisorNeg = !op.fields.isUnsigned && divisor[dw-1];

  assign partial = {rem, quot[dw-1]};
  assign trial = partial - {1'b0, divMag};
  assign fits = !trial[dw]; // no borrow

  always_ff @(posedge clk) begin
    if (load) begin
      quot <= dividendNeg ? -dividend : dividend;
      rem <= '0;
      divMag <= divisorNeg ? -divisor : divisor;
    end else if (step) begin
      rem <= fits ? trial[dw-1:0] : partial[dw-1:0];
      quot <= {quot[dw-2:0], fits};
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      isRemReg <= 1'b0;
      negQuot <= 1'b0;
      negRem <= 1'b0;
      divByZero <= 1'b0;
    end else if (load) begin
      isRemReg <= op.fields.isRem;
      negQuot <= dividendNeg ^ divisorNeg;
      negRem <= dividendNeg;
      divByZero <= divisor == '0;
    end
  end

  // by zero the quotient comes out all ones and the remainder is |dividend|
  // -2^31 / -1 needs no patch since the magnitude math wraps
  assign quotFixed = (negQuot && !divByZero) ? -quot : quot;
  assign remFixed = negRem ? -rem : rem;

  assign result = isRemReg ? remFixed : quotFixed; // holds from finish until the next load

endmodule

//--- src/execPkg.sv
package execPkg;

  localparam int dataWidth = 32;
  localparam int shamtWidth = 5;
  localparam int divSteps = 32;
  localparam int countWidth = $clog2(divSteps);
  localparam logic [countWidth-1:0] lastCount = countWidth'(divSteps - 1);

  localparam logic [3:0] divGroup = 4'b0101; // div, divu, rem, remu

  // divider sequencer states
  localparam int stateWidth = 2;
  localparam logic [stateWidth-1:0] stIdle = 2'd0;
  localparam logic [stateWidth-1:0] stLoad = 2'd1;
  localparam logic [stateWidth-1:0] stIterate = 2'd2;
  localparam logic [stateWidth-1:0] stFinish = 2'd3;

  typedef enum logic [5:0] {
    opAnd    = 6'b000000,
    opOr     = 6'b000001,
    opAdd    = 6'b000010,
    opSll    = 6'b000011,
    opSrl    = 6'b000100,
    opXor    = 6'b000101,
    opSub    = 6'b000110,
    opSra    = 6'b000111,
    opBeq    = 6'b001000,
    opBne    = 6'b001001,
    opBlt    = 6'b001010,
    opBge    = 6'b001011,
    opBltu   = 6'b001100,
    opBgeu   = 6'b001101,
    opMul    = 6'b010000,
    opMulh   = 6'b010001,
    opMulhsu = 6'b010010,
    opMulhu  = 6'b010011,
    opDiv    = 6'b010100,
    opDivu   = 6'b010101,
    opRem    = 6'b010110,
    opRemu   = 6'b010111,
    opMin    = 6'b100000,
    opMax    = 6'b100001,
    opMinu   = 6'b100010,
    opMaxu   = 6'b100011,
    opSlt    = 6'b100101,
    opSltu   = 6'b100110
  } aluOpE;

  typedef struct packed {
    logic [3:0] group;
    logic       isRem;      // remainder instead of quotient
    logic       isUnsigned;
  } aluOpFieldsT;

  // same six bits seen as a code or as divider fields
  typedef union packed {
    aluOpE       code;
    aluOpFieldsT fields;
  } aluOpU;

  typedef struct packed {
    aluOpU                op;
    logic [dataWidth-1:0] operand1;
    logic [dataWidth-1:0] operand2;
  } execReqT;

  typedef struct packed {
    logic [dataWidth-1:0] result;
    logic                 zero;
  } execRespT;

endpackage

//--- src/execUnit.sv
module execUnit (
  input  logic              clk,
  input  logic              rstN,
  input  execPkg::execReqT  req,
  input  logic              reqValid,
  output logic              busy,
  output execPkg::execRespT resp,
  output logic              respValid
);

  execPkg::execReqT reqReg;
  logic accept;
  logic isDiv;
  logic start;
  logic aluPending; // single-cycle op waiting for its response slot
  logic load;
  logic step;
  logic finish;
  logic clear;
  logic enable;
  logic last;
  logic [execPkg::dataWidth-1:0] aluResult;
  logic [execPkg::dataWidth-1:0] divResult;
  logic [execPkg::dataWidth-1:0] nextResult;

  assign accept = reqValid && !busy;
  assign isDiv = req.op.fields.group == execPkg::divGroup;
  assign start = accept && isDiv;

  always_ff @(posedge clk) begin
    if (accept) reqReg <= req;
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      aluPending <= 1'b0;
      respValid <= 1'b0;
    end else begin
      aluPending <= accept && !isDiv;
      respValid <= aluPending || finish;
    end
  end

  assign nextResult = finish ? divResult : aluResult;

  always_ff @(posedge clk) begin
    if (aluPending || finish) begin
      resp.result <= nextResult;
      resp.zero <= nextResult == '0;
    end
  end

  aluCore alu (
    .op       (reqReg.op),
    .operand1 (reqReg.operand1),
    .operand2 (reqReg.operand2),
    .result   (aluResult)
  );

  divCtrl ctrl (
    .clk    (clk),
    .rstN   (rstN),
    .start  (start),
    .last   (last),
    .load   (load),
    .step   (step),
    .finish (finish),
    .clear  (clear),
    .enable (enable),
    .busy   (busy)
  );

  divCounter counter (
    .clk    (clk),
    .rstN   (rstN),
    .clear  (clear),
    .enable (enable),
    .last   (last)
  );

  divDatapath datapath (
    .clk      (clk),
    .rstN     (rstN),
    .load     (load),
    .step     (step),
    .finish   (finish),
    .op       (reqReg.op),
    .dividend (reqReg.operand1),
    .divisor  (reqReg.operand2),
    .result   (divResult)
  );

endmodule
